// ==== flist.f ====
+incdir+include
source/csr_pkg.sv
source/csr_counters.sv
source/csr_trap_regs.sv
source/csr_unit.sv
source/csr_top.sv
tests/tb_csr_top.sv

// ==== include/csr_consts.svh ====
// CSR constants: machine-mode addresses, operation codes, cause codes and reset vector
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Counter CSRs, low and high halves
`define CSR_MCYCLE     12'hB00
`define CSR_MINSTRET   12'hB02
`define CSR_MCYCLEH    12'hB80
`define CSR_MINSTRETH  12'hB82

// Trap handling CSRs
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343

// Operation codes from rename, code 0 is undefined
`define CSR_OP_RW      2'd1    // Read-write
`define CSR_OP_RS      2'd2    // Read-set
`define CSR_OP_RC      2'd3    // Read-clear

// Illegal-instruction exception cause
`define ECAUSE_ILLEGAL 5'd2

// Trap vector seen by the ROB before software writes mtvec
`define MTVEC_RESET    32'h0000_0100

`endif

// ==== run.sh ====
#!/bin/sh
# Build the CSR testbench with Verilator, run it, and pass only if the log holds the pass line
cd "$(dirname "$0")" && rm -f sim.log && \
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_csr_top \
  -f flist.f -Mdir obj_dir > build.log 2>&1 && \
./obj_dir/Vtb_csr_top > sim.log 2>&1
grep -q "^TEST PASS$" sim.log && echo "simulation passed" || \
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== source/csr_counters.sv ====
// CSR counters: 64-bit mcycle and minstret with passive counting and CSR write override
`include "csr_consts.svh"

module csr_counters (
  input  logic              clk,
  input  logic              rst,
  input  logic              rob_ret_valid,  // One retired instruction this cycle
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic              wr_en,
  input  csr_pkg::csr_addr_t wr_addr,
  input  csr_pkg::xlen_t    wr_data,
  output csr_pkg::xlen_t    rd_data,
  output logic              rd_hit
);
  import csr_pkg::*;

  // Counter halves
  xlen_t mcycle;
  xlen_t mcycleh;
  xlen_t minstret;
  xlen_t minstreth;

  logic cyc_carry;   // mcycle about to wrap
  logic ret_carry;   // minstret about to wrap on a retire
  logic wr_mcycle;
  logic wr_mcycleh;
  logic wr_minstret;
  logic wr_minstreth;

  assign cyc_carry = &mcycle;
  assign ret_carry = rob_ret_valid & (&minstret);

  // Write decode, one strobe per half
  assign wr_mcycle    = wr_en && (wr_addr == `CSR_MCYCLE);
  assign wr_mcycleh   = wr_en && (wr_addr == `CSR_MCYCLEH);
  assign wr_minstret  = wr_en && (wr_addr == `CSR_MINSTRET);
  assign wr_minstreth = wr_en && (wr_addr == `CSR_MINSTRETH);

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle    <= '0;
      mcycleh   <= '0;
      minstret  <= '0;
      minstreth <= '0;
    end else begin
      // CSR write wins over the passive update of that half
      mcycle <= wr_mcycle ? wr_data : mcycle + 32'd1;
      if (wr_mcycleh)
        mcycleh <= wr_data;
      else if (!wr_mcycle)
        mcycleh <= mcycleh + {31'd0, cyc_carry};  // Carry dropped when low half written

      minstret <= wr_minstret ? wr_data : minstret + {31'd0, rob_ret_valid};
      if (wr_minstreth)
        minstreth <= wr_data;
      else if (!wr_minstret)
        minstreth <= minstreth + {31'd0, ret_carry};
    end
  end

  // Read decode, only the four counter addresses hit here
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (rd_addr)
      `CSR_MCYCLE:    rd_data = mcycle;
      `CSR_MCYCLEH:   rd_data = mcycleh;
      `CSR_MINSTRET:  rd_data = minstret;
      `CSR_MINSTRETH: rd_data = minstreth;
      default:        rd_hit  = 1'b0;   // Not a counter
    endcase
  end

  // Software write to minstret lands exactly, no retire mixed in
  a_minstret_write: assert property (@(posedge clk) disable iff (rst)
    (wr_minstret && !rob_ret_valid) |=> (minstret == $past(wr_data)));

endmodule

// ==== source/csr_pkg.sv ====
// CSR package: vector types shared by the CSR block and its testbench
package csr_pkg;

  // Data word
  // Operand, CSR value and result width
  typedef logic [31:0] xlen_t;

  // CSR address, low 12 bits of the immediate
  typedef logic [11:0] csr_addr_t;

  // Read-write / read-set / read-clear select
  typedef logic [1:0] csr_op_t;

  // Reorder buffer entry id
  typedef logic [6:0] robid_t;

  // Physical destination register tag
  typedef logic [5:0] preg_t;

  // Exception cause code, zero-extended into mcause on reads
  typedef logic [4:0] ecause_t;

  // Word-aligned PC, holds PC[31:2]
  // Low two bits are always zero on RV32 without compressed instructions,
  // so the exception PC and the trap vector carry only the upper 30 bits
  typedef logic [29:0] epc_t;

endpackage

// ==== source/csr_top.sv ====
// CSR block top: execution unit with counter and trap register groups
module csr_top (
  input  logic               clk,
  input  logic               rst,

  // Rename
  input  logic               rename_csr_write,
  input  csr_pkg::csr_op_t   rename_op,
  input  csr_pkg::robid_t    rename_robid,
  input  csr_pkg::preg_t     rename_rd,
  input  csr_pkg::xlen_t     rename_op1,
  input  csr_pkg::csr_addr_t rename_csr_addr,

  // Writeback
  output logic               csr_valid,
  output logic               csr_error,
  output csr_pkg::ecause_t   csr_ecause,
  output csr_pkg::robid_t    csr_robid,
  output csr_pkg::preg_t     csr_rd,
  output csr_pkg::xlen_t     csr_result,

  // ROB
  input  logic               rob_flush,
  input  logic               rob_ret_valid,
  input  logic               rob_csr_valid,
  input  csr_pkg::epc_t      rob_csr_epc,
  input  csr_pkg::ecause_t   rob_csr_ecause,
  input  csr_pkg::xlen_t     rob_csr_tval,
  output csr_pkg::epc_t      csr_tvec
);
  import csr_pkg::*;

  csr_addr_t rd_addr;
  csr_addr_t wr_addr;
  xlen_t     wr_data;
  logic      wr_en;
  xlen_t     cnt_rd_data;    // Counter group read
  logic      cnt_rd_hit;
  xlen_t     trap_rd_data;   // Trap group read
  logic      trap_rd_hit;

  csr_unit u_unit (
    .clk, .rst,
    .rename_csr_write, .rename_op, .rename_robid, .rename_rd,
    .rename_op1, .rename_csr_addr,
    .rob_flush,
    .cnt_rd_data, .cnt_rd_hit, .trap_rd_data, .trap_rd_hit,
    .csr_valid, .csr_error, .csr_ecause, .csr_robid, .csr_rd, .csr_result,
    .rd_addr, .wr_en, .wr_addr, .wr_data
  );

  csr_counters u_counters (
    .clk, .rst, .rob_ret_valid,
    .rd_addr, .wr_en, .wr_addr, .wr_data,
    .rd_data (cnt_rd_data),
    .rd_hit  (cnt_rd_hit)
  );

  csr_trap_regs u_trap (
    .clk, .rst,
    .rob_csr_valid, .rob_csr_epc, .rob_csr_ecause, .rob_csr_tval,
    .rd_addr, .wr_en, .wr_addr, .wr_data,
    .rd_data (trap_rd_data),
    .rd_hit  (trap_rd_hit),
    .csr_tvec
  );

endmodule

// ==== source/csr_trap_regs.sv ====
// Trap CSRs: mtvec, mepc, mcause, mtval and mscratch with trap capture from the ROB
`include "csr_consts.svh"

module csr_trap_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               rob_csr_valid,   // Trap commit strobe
  input  csr_pkg::epc_t      rob_csr_epc,
  input  csr_pkg::ecause_t   rob_csr_ecause,
  input  csr_pkg::xlen_t     rob_csr_tval,
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t wr_addr,
  input  csr_pkg::xlen_t     wr_data,
  output csr_pkg::xlen_t     rd_data,
  output logic               rd_hit,
  output csr_pkg::epc_t      csr_tvec         // mtvec[31:2] to the ROB
);
  import csr_pkg::*;

  xlen_t   mtvec;
  epc_t    mepc;       // PC[31:2] only
  ecause_t mcause;     // Only the cause field is kept
  xlen_t   mtval;
  xlen_t   mscratch;

  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;

  assign wr_mtvec    = wr_en && (wr_addr == `CSR_MTVEC);
  assign wr_mscratch = wr_en && (wr_addr == `CSR_MSCRATCH);
  assign wr_mepc     = wr_en && (wr_addr == `CSR_MEPC);
  assign wr_mcause   = wr_en && (wr_addr == `CSR_MCAUSE);
  assign wr_mtval    = wr_en && (wr_addr == `CSR_MTVAL);

  // Software-only registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec    <= `MTVEC_RESET;
      mscratch <= '0;
    end else begin
      if (wr_mtvec)    mtvec    <= wr_data;
      if (wr_mscratch) mscratch <= wr_data;
    end
  end

  // Trap capture beats a same-cycle CSR write
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (rob_csr_valid) begin
      mepc   <= rob_csr_epc;
      mcause <= rob_csr_ecause;
      mtval  <= rob_csr_tval;
    end else begin
      if (wr_mepc)   mepc   <= wr_data[31:2];   // Low bits dropped
      if (wr_mcause) mcause <= wr_data[4:0];
      if (wr_mtval)  mtval  <= wr_data;
    end
  end

  assign csr_tvec = mtvec[31:2];

  // Read decode for the trap group
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (rd_addr)
      `CSR_MTVEC:    rd_data = mtvec;
      `CSR_MSCRATCH: rd_data = mscratch;
      `CSR_MEPC:     rd_data = {mepc, 2'b00};     // Word aligned
      `CSR_MCAUSE:   rd_data = {27'd0, mcause};   // Zero-extended
      `CSR_MTVAL:    rd_data = mtval;
      default:       rd_hit  = 1'b0;
    endcase
  end

  // New vector reaches the ROB right after the write edge
  a_tvec_follows: assert property (@(posedge clk) disable iff (rst)
    wr_mtvec |=> (csr_tvec == $past(wr_data[31:2])));

endmodule

// ==== source/csr_unit.sv ====
// CSR execution unit: issue latch, read-modify-write, illegal detection and writeback
`include "csr_consts.svh"

module csr_unit (
  input  logic               clk,
  input  logic               rst,

  // Rename side
  input  logic               rename_csr_write,  // One-cycle strobe
  input  csr_pkg::csr_op_t   rename_op,
  input  csr_pkg::robid_t    rename_robid,
  input  csr_pkg::preg_t     rename_rd,
  input  csr_pkg::xlen_t     rename_op1,
  input  csr_pkg::csr_addr_t rename_csr_addr,

  input  logic               rob_flush,

  // Read returns from the register blocks
  input  csr_pkg::xlen_t     cnt_rd_data,
  input  logic               cnt_rd_hit,
  input  csr_pkg::xlen_t     trap_rd_data,
  input  logic               trap_rd_hit,

  // Writeback side
  output logic               csr_valid,   // Also the rename stall
  output logic               csr_error,
  output csr_pkg::ecause_t   csr_ecause,
  output csr_pkg::robid_t    csr_robid,
  output csr_pkg::preg_t     csr_rd,
  output csr_pkg::xlen_t     csr_result,

  // Shared register block port
  output csr_pkg::csr_addr_t rd_addr,
  output logic               wr_en,
  output csr_pkg::csr_addr_t wr_addr,
  output csr_pkg::xlen_t     wr_data
);
  import csr_pkg::*;

  // Issue latch
  logic      valid_q;
  csr_op_t   op_q;
  robid_t    robid_q;
  preg_t     rd_q;
  xlen_t     op1_q;
  csr_addr_t addr_q;

  logic  accept;
  logic  hit;
  logic  bad_op;
  xlen_t old_val;
  xlen_t new_val;

  // Busy for one cycle after each accept
  assign accept = rename_csr_write && !valid_q;

  always_ff @(posedge clk) begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= accept && !rob_flush;   // Flush kills the pending op
  end

  // Payload only, valid_q qualifies it
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= rename_op;
      robid_q <= rename_robid;
      rd_q    <= rename_rd;
      op1_q   <= rename_op1;
      addr_q  <= rename_csr_addr;
    end
  end

  assign rd_addr = addr_q;

  // Old value from whichever block owns the address
  assign hit     = cnt_rd_hit | trap_rd_hit;
  assign old_val = cnt_rd_hit ? cnt_rd_data : trap_rd_data;

  always_comb begin
    bad_op  = 1'b0;
    new_val = old_val;
    case (op_q)
      `CSR_OP_RW: new_val = op1_q;
      `CSR_OP_RS: new_val = old_val | op1_q;
      `CSR_OP_RC: new_val = old_val & ~op1_q;
      default:    bad_op  = 1'b1;   // Code 0 undefined
    endcase
  end

  // Unknown address or undefined op
  assign csr_error  = !hit || bad_op;
  assign csr_ecause = csr_error ? `ECAUSE_ILLEGAL : '0;
  assign csr_result = csr_error ? '0 : old_val;   // Old value back to rd

  assign csr_valid = valid_q;
  assign csr_robid = robid_q;
  assign csr_rd    = rd_q;

  // Write lands at the edge ending the valid cycle
  assign wr_en   = valid_q && !csr_error && !rob_flush;
  assign wr_addr = addr_q;
  assign wr_data = new_val;

  a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
    csr_valid |=> !csr_valid);

  a_write_needs_good_op: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> (csr_valid && !csr_error));

  // Blocks decode disjoint address sets
  a_single_owner: assert property (@(posedge clk) disable iff (rst)
    !(cnt_rd_hit && trap_rd_hit));

endmodule

// ==== tests/tb_csr_top.sv ====
// CSR block testbench driving random CSR traffic, counters, traps and flushes against a model
`include "csr_consts.svh"

module tb_csr_top;
  timeunit 1ns;
  timeprecision 100ps;
  import csr_pkg::*;

  localparam int PERIOD = 100;
  localparam int N_RW   = 40;   // Trap group read-modify-write ops
  localparam int N_CYC  = 8;
  localparam int N_INST = 20;
  localparam int N_ILL  = 20;
  localparam int N_TRAP = 10;   // Each is a commit plus three reads
  localparam int N_PAIR = 5;    // Trap-over-write, busy and flush rounds
  localparam int N_OPS  = N_RW + N_CYC + 3 + N_INST + N_ILL + 18 + N_TRAP * 4 + N_PAIR * 8;
  localparam int WATCHDOG_NS = (N_OPS * 4 + 100) * PERIOD;
  localparam int SIDE_NONE  = 0;
  localparam int SIDE_FLUSH = 1;   // rob_flush during the valid cycle
  localparam int SIDE_TRAP  = 2;   // Trap commit during the valid cycle

  logic      clk;
  logic      rst;
  logic      rename_csr_write;
  csr_op_t   rename_op;
  robid_t    rename_robid;
  preg_t     rename_rd;
  xlen_t     rename_op1;
  csr_addr_t rename_csr_addr;
  logic      rob_flush;
  logic      rob_ret_valid;
  logic      rob_csr_valid;
  epc_t      rob_csr_epc;
  ecause_t   rob_csr_ecause;
  xlen_t     rob_csr_tval;
  logic      csr_valid;
  logic      csr_error;
  ecause_t   csr_ecause;
  robid_t    csr_robid;
  preg_t     csr_rd;
  xlen_t     csr_result;
  epc_t      csr_tvec;

  // Model copy of every CSR
  xlen_t m_mcycle;
  xlen_t m_mcycleh;
  xlen_t m_minstret;
  xlen_t m_minstreth;
  xlen_t m_mtvec;
  xlen_t m_mepc;       // Low two bits kept zero
  xlen_t m_mcause;     // Zero-extended cause
  xlen_t m_mtval;
  xlen_t m_mscratch;
  logic      m_valid;  // Model issue latch
  csr_op_t   m_op;
  csr_addr_t m_addr;
  xlen_t     m_op1;

  csr_top u_dut (.*);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  function automatic logic model_known(input csr_addr_t a);
    case (a)
      `CSR_MCYCLE, `CSR_MCYCLEH, `CSR_MINSTRET, `CSR_MINSTRETH: return 1'b1;
      `CSR_MTVEC, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t model_read(input csr_addr_t a);
    case (a)
      `CSR_MCYCLE:    return m_mcycle;
      `CSR_MCYCLEH:   return m_mcycleh;
      `CSR_MINSTRET:  return m_minstret;
      `CSR_MINSTRETH: return m_minstreth;
      `CSR_MTVEC:     return m_mtvec;
      `CSR_MSCRATCH:  return m_mscratch;
      `CSR_MEPC:      return m_mepc;
      `CSR_MCAUSE:    return m_mcause;
      `CSR_MTVAL:     return m_mtval;
      default:        return 32'd0;
    endcase
  endfunction

  // Model step on the same pre-edge inputs as the DUT
  always @(posedge clk) begin
    xlen_t old;
    xlen_t nv;
    logic  wr;
    logic  cyc_wrap;
    logic  ret_wrap;
    logic  accept;
    if (rst) begin
      m_mcycle    = '0;
      m_mcycleh   = '0;
      m_minstret  = '0;
      m_minstreth = '0;
      m_mtvec     = `MTVEC_RESET;
      m_mepc      = '0;
      m_mcause    = '0;
      m_mtval     = '0;
      m_mscratch  = '0;
      m_valid     = 1'b0;
      m_op        = 2'd0;
      m_addr      = '0;
      m_op1       = '0;
    end else begin
      old = model_read(m_addr);
      case (m_op)
        `CSR_OP_RW: nv = m_op1;
        `CSR_OP_RS: nv = old | m_op1;
        default:    nv = old & ~m_op1;
      endcase
      wr = m_valid && model_known(m_addr) && (m_op != 2'd0) && !rob_flush;
      cyc_wrap = (m_mcycle == 32'hFFFF_FFFF);
      ret_wrap = rob_ret_valid && (m_minstret == 32'hFFFF_FFFF);
      if (wr && m_addr == `CSR_MCYCLE)
        m_mcycle = nv;
      else
        m_mcycle = m_mcycle + 32'd1;
      if (wr && m_addr == `CSR_MCYCLEH)
        m_mcycleh = nv;
      else if (cyc_wrap && !(wr && m_addr == `CSR_MCYCLE))
        m_mcycleh = m_mcycleh + 32'd1;   // No carry when low half written
      if (wr && m_addr == `CSR_MINSTRET)
        m_minstret = nv;
      else if (rob_ret_valid)
        m_minstret = m_minstret + 32'd1;
      if (wr && m_addr == `CSR_MINSTRETH)
        m_minstreth = nv;
      else if (ret_wrap && !(wr && m_addr == `CSR_MINSTRET))
        m_minstreth = m_minstreth + 32'd1;
      if (rob_csr_valid) begin           // Trap capture wins
        m_mepc   = {rob_csr_epc, 2'b00};
        m_mcause = {27'd0, rob_csr_ecause};
        m_mtval  = rob_csr_tval;
      end else if (wr) begin
        if (m_addr == `CSR_MEPC)
          m_mepc = nv & 32'hFFFF_FFFC;
        if (m_addr == `CSR_MCAUSE)
          m_mcause = {27'd0, nv[4:0]};
        if (m_addr == `CSR_MTVAL)
          m_mtval = nv;
      end
      if (wr && m_addr == `CSR_MTVEC)
        m_mtvec = nv;
      if (wr && m_addr == `CSR_MSCRATCH)
        m_mscratch = nv;
      accept = rename_csr_write && !m_valid;   // Busy cycle stalls rename
      if (accept) begin
        m_op   = rename_op;
        m_addr = rename_csr_addr;
        m_op1  = rename_op1;
      end
      m_valid = accept && !rob_flush;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_robid(input string name, input robid_t exp, input robid_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_preg(input string name, input preg_t exp, input preg_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cause(input string name, input ecause_t exp, input ecause_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_vec(input string name, input epc_t exp, input epc_t act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  // Valid pulse and trap vector checked every settled cycle
  always @(negedge clk) begin
    if (!rst) begin
      check_flag("csr_valid", m_valid, csr_valid);
      check_vec("csr_tvec", m_mtvec[31:2], csr_tvec);
    end
  end

  // At most one random retire per cycle
  initial begin
    rob_ret_valid <= 1'b0;
    forever begin
      @(posedge clk);
      rob_ret_valid <= !rst && ($urandom % 3 == 0);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout: the CSR test sequence did not finish in time");
  end

  // Index 6..8 is the read-write trap group
  function automatic csr_addr_t pick_addr(input int i);
    case (i)
      0: return `CSR_MCYCLE;
      1: return `CSR_MCYCLEH;
      2: return `CSR_MINSTRET;
      3: return `CSR_MINSTRETH;
      4: return `CSR_MCAUSE;
      5: return `CSR_MTVAL;
      6: return `CSR_MSCRATCH;
      7: return `CSR_MEPC;
      default: return `CSR_MTVEC;
    endcase
  endfunction

  function automatic csr_addr_t unknown_addr();
    xlen_t w;
    w = $urandom;
    while (model_known(w[11:0]))
      w = $urandom;
    return w[11:0];
  endfunction

  function automatic csr_op_t rand_op();
    xlen_t w;
    w = $urandom % 3;
    return w[1:0] + 2'd1;
  endfunction

  task automatic drive_request(input csr_op_t op, input csr_addr_t addr, input xlen_t op1,
                               input robid_t robid, input preg_t rd);
    rename_csr_write <= 1'b1;
    rename_op        <= op;
    rename_csr_addr  <= addr;
    rename_op1       <= op1;
    rename_robid     <= robid;
    rename_rd        <= rd;
  endtask

  task automatic drive_trap();
    xlen_t w;
    w = $urandom;
    rob_csr_valid  <= 1'b1;
    rob_csr_epc    <= w[31:2];
    rob_csr_ecause <= w[4:0];
    rob_csr_tval   <= $urandom;
  endtask

  task automatic wait_valid(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!csr_valid && n < 4) begin
      n++;
      @(negedge clk);
    end
    if (!csr_valid)
      abort_run({"csr_valid never rose for ", name});
  endtask

  // Expected response from the model state in the valid cycle
  task automatic check_response(input string name, input csr_op_t op, input csr_addr_t addr,
                                input robid_t robid, input preg_t rd);
    logic bad;
    bad = !model_known(addr) || op == 2'd0;
    check_flag({name, " error"}, bad, csr_error);
    if (bad)
      check_cause({name, " cause"}, `ECAUSE_ILLEGAL, csr_ecause);
    check_word({name, " result"}, bad ? 32'd0 : model_read(addr), csr_result);
    check_robid({name, " robid"}, robid, csr_robid);
    check_preg({name, " rd"}, rd, csr_rd);
  endtask

  task automatic do_op(input string name, input csr_op_t op, input csr_addr_t addr,
                       input xlen_t op1, input int side, output xlen_t res);
    xlen_t w;
    w = $urandom;
    @(posedge clk);
    drive_request(op, addr, op1, w[6:0], w[12:7]);
    @(posedge clk);                      // Accept edge
    rename_csr_write <= 1'b0;
    rob_flush        <= (side == SIDE_FLUSH);
    if (side == SIDE_TRAP)
      drive_trap();
    wait_valid(name);
    check_response(name, op, addr, w[6:0], w[12:7]);
    res = csr_result;
    @(posedge clk);                      // Write edge
    rob_flush     <= 1'b0;
    rob_csr_valid <= 1'b0;
  endtask

  task automatic read_csr(input string name, input csr_addr_t addr, output xlen_t res);
    do_op(name, `CSR_OP_RS, addr, 32'd0, SIDE_NONE, res);
  endtask

  task automatic read_all(input string name);
    xlen_t r;
    for (int i = 0; i < 9; i++)
      read_csr(name, pick_addr(i), r);
  endtask

  task automatic read_trap_regs(input string name);
    xlen_t r;
    read_csr({name, " mepc"}, `CSR_MEPC, r);
    read_csr({name, " mcause"}, `CSR_MCAUSE, r);
    read_csr({name, " mtval"}, `CSR_MTVAL, r);
  endtask

  // Second strobe held through the busy cycle must be dropped
  task automatic busy_round(input string name);
    xlen_t w;
    xlen_t r;
    w = $urandom;
    @(posedge clk);
    drive_request(`CSR_OP_RS, `CSR_MTVEC, 32'd0, w[6:0], w[12:7]);
    @(posedge clk);
    drive_request(`CSR_OP_RW, `CSR_MSCRATCH, ~w, w[13:7], w[18:13]);
    wait_valid(name);
    check_response(name, `CSR_OP_RS, `CSR_MTVEC, w[6:0], w[12:7]);
    @(posedge clk);
    rename_csr_write <= 1'b0;
    read_csr({name, " mscratch"}, `CSR_MSCRATCH, r);   // Still the model value
  endtask

  initial begin
    xlen_t r;
    xlen_t h0;
    xlen_t w;
    void'($urandom(73438));
    rst              <= 1'b1;
    rename_csr_write <= 1'b0;
    rename_op        <= 2'd0;
    rename_robid     <= '0;
    rename_rd        <= '0;
    rename_op1       <= '0;
    rename_csr_addr  <= '0;
    rob_flush        <= 1'b0;
    rob_csr_valid    <= 1'b0;
    rob_csr_epc      <= '0;
    rob_csr_ecause   <= '0;
    rob_csr_tval     <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_RW; i++)
      do_op("trap rmw", rand_op(), pick_addr(6 + int'($urandom % 3)), $urandom, SIDE_NONE, r);

    for (int i = 0; i < N_CYC; i++)
      read_csr("cycle read", pick_addr(int'($urandom % 2)), r);
    read_csr("mcycleh before", `CSR_MCYCLEH, h0);
    do_op("mcycle near wrap", `CSR_OP_RW, `CSR_MCYCLE, 32'hFFFF_FFF0, SIDE_NONE, r);
    repeat (20) @(posedge clk);          // Let mcycle wrap
    read_csr("mcycleh after wrap", `CSR_MCYCLEH, r);
    check_word("mcycleh carry", h0 + 32'd1, r);

    for (int i = 0; i < N_INST; i++) begin
      w = $urandom % 4;
      case (w[1:0])
        2'd0: do_op("minstret near wrap", `CSR_OP_RW, `CSR_MINSTRET, 32'hFFFF_FFFA,
                    SIDE_NONE, r);
        2'd1: do_op("minstret write", `CSR_OP_RW, `CSR_MINSTRET, $urandom, SIDE_NONE, r);
        2'd2: read_csr("minstret read", `CSR_MINSTRET, r);
        default: read_csr("minstreth read", `CSR_MINSTRETH, r);
      endcase
    end

    for (int i = 0; i < N_ILL; i++) begin
      w = $urandom;
      if (w[0])
        do_op("undefined op", 2'd0, pick_addr(int'($urandom % 9)), w, SIDE_NONE, r);
      else
        do_op("unknown address", rand_op(), unknown_addr(), w, SIDE_NONE, r);
    end
    read_all("after illegal");

    for (int i = 0; i < N_TRAP; i++) begin
      @(posedge clk);
      drive_trap();
      @(posedge clk);
      rob_csr_valid <= 1'b0;
      read_trap_regs("trap commit");
    end
    for (int i = 0; i < N_PAIR; i++) begin
      do_op("mepc write under trap", `CSR_OP_RW, `CSR_MEPC, $urandom, SIDE_TRAP, r);
      read_trap_regs("trap over write");
    end

    for (int i = 0; i < N_PAIR; i++) begin
      busy_round("busy strobe");
      do_op("flushed write", `CSR_OP_RW, `CSR_MSCRATCH, $urandom, SIDE_FLUSH, r);
      read_csr("mscratch after flush", `CSR_MSCRATCH, r);
    end
    read_all("final");

    repeat (2) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule
